// File: design/cpu_types_pkg.sv
// Data width types for register values, imported by every block of the register file
package cpu_types_pkg;

	// ================================================
	// Register value widths
	// ================================================

	// Width of one architectural register
	localparam int VALUE_W = 32;

	// Number of lanes moved together in a group transfer
	localparam int NUM_LANES = 4;

	// One register value
	typedef logic [VALUE_W-1:0] value_t;

	// Four register values side by side, lane 0 in the low bits
	typedef value_t [NUM_LANES-1:0] quad_value_t;

endpackage

// File: design/regmap_pkg.sv
// Register map types, write port structs and the operating mode encoding of the register file
package regmap_pkg;

	// ================================================
	// Register numbering
	// ================================================

	// Number of four-lane groups, register 4g+l lives in group g, lane l
	localparam int NUM_GROUPS = 16;

	typedef logic [5:0] reg_addr_t;
	typedef logic [3:0] group_addr_t;
	typedef logic [1:0] lane_t;

	// Operating mode, selects which stack pointer register 63 maps to
	typedef enum logic [1:0] {
		MODE_APP  = 2'd0,
		MODE_SUP  = 2'd1,
		MODE_HYP  = 2'd2,
		MODE_MACH = 2'd3
	} op_mode_t;

	// ================================================
	// Write port bundles
	// ================================================

	// Single register write from the execution side
	typedef struct packed {
		logic en;
		reg_addr_t addr;
		cpu_types_pkg::value_t data;
	} reg_write_t;

	// Whole group write, driven by the context engine during a restore
	typedef struct packed {
		logic en;
		group_addr_t group;
		cpu_types_pkg::quad_value_t data;
	} group_write_t;

endpackage

// File: design/gpr_bank.sv
// Four-lane general register storage with single write, group write/read and four read ports
module gpr_bank #(
	parameter regmap_pkg::reg_addr_t SP_REG = 6'd63,
	parameter regmap_pkg::reg_addr_t SC_REG = 6'd53
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  regmap_pkg::reg_write_t      wr,
	input  regmap_pkg::group_write_t    gw,
	input  regmap_pkg::group_addr_t     gra,
	output cpu_types_pkg::quad_value_t  go,
	input  regmap_pkg::reg_addr_t       ra0,
	input  regmap_pkg::reg_addr_t       ra1,
	input  regmap_pkg::reg_addr_t       ra2,
	input  regmap_pkg::reg_addr_t       ra3,
	output cpu_types_pkg::value_t       o0,
	output cpu_types_pkg::value_t       o1,
	output cpu_types_pkg::value_t       o2,
	output cpu_types_pkg::value_t       o3,
	input  cpu_types_pkg::value_t       sp_cur,
	output cpu_types_pkg::value_t       sc
);
	import cpu_types_pkg::*;
	import regmap_pkg::*;

	// ================================================
	// Storage
	// ================================================

	// One 16-entry array per lane, indexed by group number
	// Lane l of group g holds register 4g+l
	value_t lane_mem [0:NUM_LANES-1][0:NUM_GROUPS-1];

	// Group addressed by whichever write is active this cycle
	group_addr_t wr_group;

	// Lane of the single write
	lane_t wr_lane;

	// Single write that actually lands, a group write in the same cycle drops it
	logic single_we;

	// Storage comes up cleared so that a save before any write reads zeros
	initial begin
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int g = 0; g < NUM_GROUPS; g++) begin
				lane_mem[l][g] = '0;
			end
		end
	end

	// ================================================
	// Write side
	// ================================================

	// The group write owns the group address when both ports are active
	always_comb begin
		wr_group = gw.en ? gw.group : wr.addr[5:2];
		wr_lane = wr.addr[1:0];
		single_we = wr.en && !gw.en;
	end

	// A group write fills all four lanes of its group at once
	// Otherwise only the addressed lane takes the single write
	always_ff @(posedge clk) begin
		for (int l = 0; l < NUM_LANES; l++) begin
			if (gw.en) begin
				lane_mem[l][wr_group] <= gw.data[l];
			end else if (single_we && wr_lane == lane_t'(l)) begin
				lane_mem[l][wr_group] <= wr.data;
			end
		end
	end

	// Shadow of the status/control register
	// Only a single write that lands updates it, one cycle after the write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sc <= '0;
		end else if (single_we && wr.addr == SC_REG) begin
			sc <= wr.data;
		end
	end

	// ================================================
	// Read side
	// ================================================

	// Group read for the context engine, straight from storage without bypass
	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			go[l] = lane_mem[l][gra];
		end
	end

	// Resolve one read port
	// Register 0 is hardwired to zero and wins over everything
	// Next the pending single write is forwarded in the same cycle
	// Register 63 then maps to the stack pointer of the current mode
	task automatic lookup(
		input  reg_addr_t  ra,
		input  value_t     stored,
		input  logic       byp,
		input  reg_write_t w,
		input  value_t     sp,
		output value_t     o
	);
		if (ra == '0) begin
			o = '0;
		end else if (byp && ra == w.addr) begin
			o = w.data;
		end else if (ra == SP_REG) begin
			o = sp;
		end else begin
			o = stored;
		end
	endtask

	// The four read ports, all combinational
	// The stored value is picked here: lane from the low bits, group from the high bits
	always_comb begin
		lookup(ra0, lane_mem[ra0[1:0]][ra0[5:2]], single_we, wr, sp_cur, o0);
		lookup(ra1, lane_mem[ra1[1:0]][ra1[5:2]], single_we, wr, sp_cur, o1);
		lookup(ra2, lane_mem[ra2[1:0]][ra2[5:2]], single_we, wr, sp_cur, o2);
		lookup(ra3, lane_mem[ra3[1:0]][ra3[5:2]], single_we, wr, sp_cur, o3);
	end

endmodule

// File: design/stack_ptr_bank.sv
// Banked stack pointers, one per operating mode, presenting the current mode's pointer
module stack_ptr_bank #(
	parameter regmap_pkg::reg_addr_t SP_REG = 6'd63
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  regmap_pkg::reg_write_t wr,
	input  regmap_pkg::op_mode_t   mode,
	output cpu_types_pkg::value_t  sp_cur
);
	import cpu_types_pkg::*;

	// ================================================
	// Pointer registers
	// ================================================

	// Number of banked pointers, one per operating mode
	localparam int NUM_SP = 4;

	// Indexed directly by the mode encoding
	// Entry 0 application, 1 supervisor, 2 hypervisor, 3 machine
	value_t sp_q [0:NUM_SP-1];

	// A write to the stack pointer register targets the pointer of the mode in force
	logic sp_we;

	always_comb begin
		sp_we = wr.en && wr.addr == SP_REG;
	end

	// There is no group port here, so a pointer write goes through even when
	// the register array drops the single write for a restore
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int m = 0; m < NUM_SP; m++) begin
				sp_q[m] <= '0;
			end
		end else if (sp_we) begin
			sp_q[mode] <= wr.data;
		end
	end

	// ================================================
	// Current pointer
	// ================================================

	// Follows the mode input with no delay
	// The bank forwards a same-cycle write through its own bypass
	always_comb begin
		sp_cur = sp_q[mode];
	end

endmodule

// File: design/ctx_engine.sv
// Context save/restore sequencer moving one register group per cycle to or from a slot store
module ctx_engine #(
	parameter int NUM_CTX = 4
) (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  logic                                         save_start,
	input  logic                                         restore_start,
	input  logic [$clog2(NUM_CTX > 1 ? NUM_CTX : 2)-1:0] ctx_slot,
	output regmap_pkg::group_addr_t                      gra,
	input  cpu_types_pkg::quad_value_t                   go,
	output regmap_pkg::group_write_t                     gw,
	output logic                                         ctx_busy,
	output logic                                         ctx_done
);
	import cpu_types_pkg::*;
	import regmap_pkg::*;

	// Width of the slot number, at least one bit
	localparam int SLOT_W = $clog2(NUM_CTX > 1 ? NUM_CTX : 2);

	// ================================================
	// Sequencer state
	// ================================================

	typedef enum logic [1:0] {
		CTX_IDLE,
		CTX_SAVE,
		CTX_RESTORE,
		CTX_DONE
	} ctx_state_t;

	ctx_state_t state_q;
	ctx_state_t state_d;

	// Group being transferred in the current busy cycle
	group_addr_t grp_q;

	// Slot captured when the transfer starts, held for all 16 groups
	logic [SLOT_W-1:0] slot_q;

	// Engine can take a new request, this includes the done cycle
	logic start_ok;

	// A request is taken this cycle
	logic start_take;

	// Current group is the final one of the sweep
	logic last_grp;

	// ================================================
	// Context store
	// ================================================

	// One full register image per slot, one quad entry per group
	quad_value_t ctx_mem [0:NUM_CTX-1][0:NUM_GROUPS-1];

	// Slots read as zero until something is saved into them
	initial begin
		for (int s = 0; s < NUM_CTX; s++) begin
			for (int g = 0; g < NUM_GROUPS; g++) begin
				ctx_mem[s][g] = '0;
			end
		end
	end

	// A save writes the group that the bank presents on go this cycle
	always_ff @(posedge clk) begin
		if (state_q == CTX_SAVE) begin
			ctx_mem[slot_q][grp_q] <= go;
		end
	end

	// ================================================
	// Control
	// ================================================

	always_comb begin
		start_ok = (state_q == CTX_IDLE) || (state_q == CTX_DONE);
		start_take = start_ok && (save_start || restore_start);
		last_grp = grp_q == group_addr_t'(NUM_GROUPS - 1);
	end

	// Save has priority when both starts arrive together
	// Starts while a transfer is running are ignored
	always_comb begin
		state_d = state_q;
		case (state_q)
			CTX_IDLE, CTX_DONE: begin
				if (save_start) begin
					state_d = CTX_SAVE;
				end else if (restore_start) begin
					state_d = CTX_RESTORE;
				end else begin
					state_d = CTX_IDLE;
				end
			end
			CTX_SAVE, CTX_RESTORE: begin
				// Sixteen busy cycles, then a single done cycle
				if (last_grp) begin
					state_d = CTX_DONE;
				end
			end
			default: begin
				state_d = CTX_IDLE;
			end
		endcase
	end

	// The group counter restarts at zero whenever the engine is free and
	// steps once per busy cycle, wrapping back to zero after group 15
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= CTX_IDLE;
			grp_q <= '0;
			slot_q <= '0;
		end else begin
			state_q <= state_d;
			if (start_ok) begin
				grp_q <= '0;
			end else begin
				grp_q <= grp_q + 4'd1;
			end
			if (start_take) begin
				slot_q <= ctx_slot;
			end
		end
	end

	// ================================================
	// Outputs
	// ================================================

	always_comb begin
		ctx_busy = (state_q == CTX_SAVE) || (state_q == CTX_RESTORE);
		ctx_done = state_q == CTX_DONE;
		gra = grp_q;

		// A restore writes the stored image back one group per cycle
		gw.en = state_q == CTX_RESTORE;
		gw.group = grp_q;
		gw.data = ctx_mem[slot_q][grp_q];
	end

endmodule

// File: design/regfile_top.sv
// Top of the integer register file subsystem, connecting the bank, stack pointers and context engine
module regfile_top #(
	parameter regmap_pkg::reg_addr_t SP_REG = 6'd63,
	parameter regmap_pkg::reg_addr_t SC_REG = 6'd53,
	parameter int NUM_CTX = 4
) (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  regmap_pkg::reg_write_t                       wr,
	input  regmap_pkg::reg_addr_t                        ra0,
	input  regmap_pkg::reg_addr_t                        ra1,
	input  regmap_pkg::reg_addr_t                        ra2,
	input  regmap_pkg::reg_addr_t                        ra3,
	input  regmap_pkg::op_mode_t                         mode,
	input  logic                                         save_start,
	input  logic                                         restore_start,
	input  logic [$clog2(NUM_CTX > 1 ? NUM_CTX : 2)-1:0] ctx_slot,
	output cpu_types_pkg::value_t                        o0,
	output cpu_types_pkg::value_t                        o1,
	output cpu_types_pkg::value_t                        o2,
	output cpu_types_pkg::value_t                        o3,
	output cpu_types_pkg::value_t                        sc,
	output logic                                         ctx_busy,
	output logic                                         ctx_done
);
	import cpu_types_pkg::*;
	import regmap_pkg::*;

	// ================================================
	// Internal connections
	// ================================================

	// Stack pointer of the current mode, read through register 63
	value_t sp_cur;

	// Group transfer path between the bank and the context engine
	group_write_t gw;
	group_addr_t gra;
	quad_value_t go;

	gpr_bank #(
		.SP_REG(SP_REG),
		.SC_REG(SC_REG)
	) u_gpr_bank (
		.clk    (clk),
		.rst_n  (rst_n),
		.wr     (wr),
		.gw     (gw),
		.gra    (gra),
		.go     (go),
		.ra0    (ra0),
		.ra1    (ra1),
		.ra2    (ra2),
		.ra3    (ra3),
		.o0     (o0),
		.o1     (o1),
		.o2     (o2),
		.o3     (o3),
		.sp_cur (sp_cur),
		.sc     (sc)
	);

	// Sees every single write, including those the bank drops for a restore
	stack_ptr_bank #(
		.SP_REG(SP_REG)
	) u_stack_ptr_bank (
		.clk    (clk),
		.rst_n  (rst_n),
		.wr     (wr),
		.mode   (mode),
		.sp_cur (sp_cur)
	);

	ctx_engine #(
		.NUM_CTX(NUM_CTX)
	) u_ctx_engine (
		.clk           (clk),
		.rst_n         (rst_n),
		.save_start    (save_start),
		.restore_start (restore_start),
		.ctx_slot      (ctx_slot),
		.gra           (gra),
		.go            (go),
		.gw            (gw),
		.ctx_busy      (ctx_busy),
		.ctx_done      (ctx_done)
	);

endmodule

// File: dv/regfile_props.sv
// Concurrent checks on the context engine handshake levels, bound into ctx_engine by the testbench
module regfile_props (
	input logic clk,
	input logic rst_n,
	input logic save_start,
	input logic restore_start,
	input logic ctx_busy,
	input logic ctx_done,
	input logic gw_en
);
	timeunit 1ns;
	timeprecision 100ps;

	// ================================================
	// Busy length tracking
	// ================================================

	// Number of busy cycles seen so far in the current transfer
	logic [4:0] busy_len;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_len <= '0;
		end else if (ctx_busy) begin
			busy_len <= busy_len + 5'd1;
		end else begin
			busy_len <= '0;
		end
	end

	// ================================================
	// Properties
	// ================================================

	// Done is a single-cycle pulse
	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		ctx_done |=> !ctx_done)
		else $error("ctx_done stayed high for more than one cycle");

	// Done and busy never overlap
	done_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
		!(ctx_done && ctx_busy))
		else $error("ctx_done and ctx_busy were high together");

	// A start taken while the engine is free makes it busy on the next cycle
	start_to_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(!ctx_busy && (save_start || restore_start)) |=> ctx_busy)
		else $error("engine did not go busy after a start");

	// Sixteen busy cycles at most, one per group
	busy_bounded: assert property (@(posedge clk) disable iff (!rst_n)
		ctx_busy |-> busy_len < 5'd16)
		else $error("ctx_busy lasted longer than sixteen cycles");

	// When busy drops, exactly sixteen cycles have gone by
	busy_full: assert property (@(posedge clk) disable iff (!rst_n)
		(!ctx_busy && $past(ctx_busy)) |-> busy_len == 5'd16)
		else $error("ctx_busy ended before sixteen cycles");

	// Group writes only happen inside a transfer
	gw_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
		gw_en |-> ctx_busy)
		else $error("group write outside of a busy transfer");

endmodule

// File: dv/regfile_tb.sv
// Self-checking testbench for regfile_top, random stimulus against a reference model of the register file
module regfile_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import cpu_types_pkg::*;
	import regmap_pkg::*;

	localparam reg_addr_t SP_REG = 6'd63;
	localparam reg_addr_t SC_REG = 6'd53;
	localparam int NUM_CTX = 4;
	localparam int SLOT_W = $clog2(NUM_CTX);

	// ================================================
	// DUT signals
	// ================================================

	logic clk;
	logic rst_n;
	reg_write_t wr;
	reg_addr_t ra [0:3];
	op_mode_t mode;
	logic save_start;
	logic restore_start;
	logic [SLOT_W-1:0] ctx_slot;
	value_t rd [0:3];
	value_t sc;
	logic ctx_busy;
	logic ctx_done;

	// Values for the next cycle, set up by the stimulus and driven on the clock edge
	reg_write_t nxt_wr;
	reg_addr_t nxt_ra [0:3];
	op_mode_t nxt_mode;
	logic nxt_save;
	logic nxt_restore;
	logic [SLOT_W-1:0] nxt_slot;

	// ================================================
	// Reference model
	// ================================================

	value_t m_regs [0:63];
	value_t m_sp [0:3];
	value_t m_sc;
	value_t m_ctx [0:NUM_CTX-1][0:63];

	// Engine position: 0 idle, 1 to 16 busy on group cnt-1, 17 done
	int eng_cnt;
	logic eng_save;
	logic [SLOT_W-1:0] eng_slot;

	// Register image taken when a save starts
	value_t image [0:63];
	reg_addr_t last_addr;
	logic [31:0] seed = 32'h68d8_2c5a;

	regfile_top #(
		.SP_REG(SP_REG),
		.SC_REG(SC_REG),
		.NUM_CTX(NUM_CTX)
	) dut (
		.clk(clk), .rst_n(rst_n), .wr(wr),
		.ra0(ra[0]), .ra1(ra[1]), .ra2(ra[2]), .ra3(ra[3]),
		.mode(mode), .save_start(save_start), .restore_start(restore_start),
		.ctx_slot(ctx_slot),
		.o0(rd[0]), .o1(rd[1]), .o2(rd[2]), .o3(rd[3]),
		.sc(sc), .ctx_busy(ctx_busy), .ctx_done(ctx_done)
	);

	always #10 clk = ~clk;

	// LCG step, halves swapped so that the low bits come from the better upper state bits
	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return {seed[15:0], seed[31:16]};
	endfunction

	function automatic logic eng_busy();
		return eng_cnt >= 1 && eng_cnt <= 16;
	endfunction

	// Read result by the port priority: zero, bypass, stack pointer, storage
	function automatic value_t expected_read(input reg_addr_t a);
		if (a == 6'd0) begin
			return '0;
		end
		if (nxt_wr.en && !(eng_busy() && !eng_save) && a == nxt_wr.addr) begin
			return nxt_wr.data;
		end
		if (a == SP_REG) begin
			return m_sp[nxt_mode];
		end
		return m_regs[a];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			$display(">>> FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// Apply the clock edge at the end of the current cycle to the model
	task automatic update_model();
		int base;
		logic restoring;
		base = (eng_cnt - 1) * 4;
		restoring = eng_busy() && !eng_save;
		// A save captures storage as it was before this edge
		if (eng_busy()) begin
			for (int l = 0; l < 4; l++) begin
				if (eng_save) begin
					m_ctx[eng_slot][base + l] = m_regs[base + l];
				end else begin
					m_regs[base + l] = m_ctx[eng_slot][base + l];
				end
			end
		end
		// The group write drops the single write, the stack pointer still sees it
		if (nxt_wr.en && !restoring) begin
			m_regs[nxt_wr.addr] = nxt_wr.data;
			if (nxt_wr.addr == SC_REG) begin
				m_sc = nxt_wr.data;
			end
		end
		if (nxt_wr.en && nxt_wr.addr == SP_REG) begin
			m_sp[nxt_mode] = nxt_wr.data;
		end
		if ((eng_cnt == 0 || eng_cnt == 17) && (nxt_save || nxt_restore)) begin
			eng_cnt = 1;
			eng_save = nxt_save;
			eng_slot = nxt_slot;
		end else if (eng_busy()) begin
			eng_cnt++;
		end else begin
			eng_cnt = 0;
		end
	endtask

	// Drive one cycle, check every output mid-cycle, then advance the model
	task automatic run_cycle();
		@(posedge clk);
		wr <= nxt_wr;
		for (int p = 0; p < 4; p++) begin
			ra[p] <= nxt_ra[p];
		end
		mode <= nxt_mode;
		save_start <= nxt_save;
		restore_start <= nxt_restore;
		ctx_slot <= nxt_slot;
		@(negedge clk);
		for (int p = 0; p < 4; p++) begin
			check_value($sformatf("o%0d", p), rd[p], expected_read(nxt_ra[p]));
		end
		check_value("sc", sc, m_sc);
		check_value("ctx_busy", 32'(ctx_busy), 32'(eng_busy()));
		check_value("ctx_done", 32'(ctx_done), 32'(eng_cnt == 17));
		update_model();
	endtask

	task automatic random_reads();
		logic [31:0] r;
		for (int p = 0; p < 4; p++) begin
			r = next_rand();
			nxt_ra[p] = r[5:0];
		end
	endtask

	// Random write with frequent hits on the stack pointer and sc, reads aimed at the write
	task automatic random_cycle();
		logic [31:0] r;
		random_reads();
		r = next_rand();
		nxt_mode = op_mode_t'(r[1:0]);
		nxt_save = 1'b0;
		nxt_restore = 1'b0;
		nxt_wr.en = r[3:2] != 2'b00;
		case (r[6:4])
			3'd0: nxt_wr.addr = SC_REG;
			3'd1: nxt_wr.addr = SP_REG;
			default: nxt_wr.addr = r[13:8];
		endcase
		nxt_wr.data = next_rand();
		if (r[7]) begin
			nxt_ra[0] = nxt_wr.addr;
		end
		nxt_ra[1] = last_addr;
		run_cycle();
		if (nxt_wr.en) begin
			last_addr = nxt_wr.addr;
		end
	endtask

	// Run until ctx_done, optionally hitting the restored group with single writes
	task automatic wait_for_done(input logic hit_group);
		int n;
		logic done_seen;
		logic [31:0] r;
		n = 0;
		done_seen = 1'b0;
		while (!done_seen && n < 40) begin
			random_reads();
			r = next_rand();
			nxt_wr = '0;
			// Starts while busy must be ignored
			nxt_save = eng_busy() && r[0];
			nxt_restore = eng_busy() && r[1];
			if (hit_group && eng_busy()) begin
				nxt_wr.en = 1'b1;
				nxt_wr.addr = {group_addr_t'(eng_cnt - 1), r[3:2]};
				nxt_wr.data = next_rand();
				nxt_ra[0] = nxt_wr.addr;
			end
			run_cycle();
			n++;
			done_seen = ctx_done;
		end
		if (!done_seen) begin
			$display("Timed out: ctx_done did not arrive within 40 cycles of the start");
			$display(">>> FAIL");
			$fatal(1, "context engine timeout");
		end
		check_value("ctx_done latency", 32'(n), 32'd17);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		wr = '0;
		mode = MODE_APP;
		save_start = 1'b0;
		restore_start = 1'b0;
		ctx_slot = '0;
		nxt_wr = '0;
		nxt_mode = MODE_APP;
		nxt_save = 1'b0;
		nxt_restore = 1'b0;
		nxt_slot = '0;
		last_addr = '0;
		eng_cnt = 0;
		eng_save = 1'b0;
		eng_slot = '0;
		m_sc = '0;
		for (int p = 0; p < 4; p++) begin
			ra[p] = '0;
			nxt_ra[p] = '0;
			m_sp[p] = '0;
		end
		for (int a = 0; a < 64; a++) begin
			m_regs[a] = '0;
			for (int s = 0; s < NUM_CTX; s++) begin
				m_ctx[s][a] = '0;
			end
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// ================================================
		// Reset values, then random traffic
		// ================================================

		// Every mode's stack pointer and sc start at zero
		for (int m = 0; m < 4; m++) begin
			nxt_mode = op_mode_t'(m[1:0]);
			nxt_ra[0] = SP_REG;
			nxt_ra[1] = SC_REG;
			run_cycle();
		end
		for (int i = 0; i < 300; i++) begin
			random_cycle();
		end

		// Each mode writes its own pointer, then all four are read back
		for (int m = 0; m < 4; m++) begin
			nxt_mode = op_mode_t'(m[1:0]);
			nxt_wr.en = 1'b1;
			nxt_wr.addr = SP_REG;
			nxt_wr.data = next_rand();
			run_cycle();
			nxt_wr = '0;
			for (int k = 0; k < 4; k++) begin
				nxt_mode = op_mode_t'(k[1:0]);
				nxt_ra[k] = SP_REG;
				run_cycle();
			end
		end

		// sc follows a write one cycle later
		nxt_wr.en = 1'b1;
		nxt_wr.addr = SC_REG;
		nxt_wr.data = next_rand();
		run_cycle();
		nxt_wr = '0;
		run_cycle();
		check_value("sc after write", sc, m_regs[SC_REG]);

		// ================================================
		// Save, scramble, restore
		// ================================================

		for (int a = 0; a < 64; a++) begin
			image[a] = m_regs[a];
		end
		// Both starts at once, save takes priority
		nxt_slot = SLOT_W'(next_rand());
		nxt_save = 1'b1;
		nxt_restore = 1'b1;
		run_cycle();
		wait_for_done(1'b0);

		for (int a = 0; a < 64; a++) begin
			random_reads();
			nxt_wr.en = 1'b1;
			nxt_wr.addr = reg_addr_t'(a);
			nxt_wr.data = next_rand();
			run_cycle();
		end
		nxt_wr = '0;
		nxt_restore = 1'b1;
		run_cycle();
		wait_for_done(1'b1);

		// Read back four registers per cycle against the image
		nxt_save = 1'b0;
		nxt_restore = 1'b0;
		for (int b = 0; b < 64; b += 4) begin
			for (int p = 0; p < 4; p++) begin
				nxt_ra[p] = reg_addr_t'(b + p);
			end
			run_cycle();
			for (int p = 0; p < 4; p++) begin
				if (b + p != 0 && b + p != 63) begin
					check_value($sformatf("o%0d restored", p), rd[p], image[b + p]);
				end
			end
		end

		for (int i = 0; i < 100; i++) begin
			random_cycle();
		end
		$display(">>> PASS");
		$finish;
	end

	bind ctx_engine regfile_props u_props (
		.clk(clk),
		.rst_n(rst_n),
		.save_start(save_start),
		.restore_start(restore_start),
		.ctx_busy(ctx_busy),
		.ctx_done(ctx_done),
		.gw_en(gw.en)
	);

endmodule

// File: all.f
design/cpu_types_pkg.sv
design/regmap_pkg.sv
design/gpr_bank.sv
design/stack_ptr_bank.sv
design/ctx_engine.sv
design/regfile_top.sv
dv/regfile_props.sv
dv/regfile_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the register file testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -sv \
	-f all.f \
	--top-module regfile_tb \
	-Mdir obj_dir \
	-o sim_regfile

./obj_dir/sim_regfile 2>&1 | tee sim.log

if grep -qx '>>> PASS' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
